// ==== include/feat_cfg.svh ====
// Feature store configuration
`ifndef FEAT_CFG_SVH
`define FEAT_CFG_SVH

// --------------------
// tile geometry
// --------------------
// tiles per row, then tile rows
`define FEAT_TILES_X 6
`define FEAT_TILES_Y 5

// --------------------
// data widths
// --------------------
// full feature vector and one bank word
`define FEAT_W 192
`define FEAT_MEM_W 64
// words per tile, rounded up
`define FEAT_BEATS ((`FEAT_W + `FEAT_MEM_W - 1) / `FEAT_MEM_W)

// --------------------
// memory layout
// --------------------
// first word of tile 0; odd on purpose so start banks alternate
`define FEAT_BASE_WORD 3
`define FEAT_BANK_DEPTH 48
`define FEAT_TAG_W 8

`endif

// ==== run_sim.sh ====
#!/bin/sh
# build and run the feature fetch simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module feat_fetch_tb -o feat_fetch_sim

# a $fatal in the testbench gives a nonzero exit status
./obj_dir/feat_fetch_sim

// ==== sim.f ====
+incdir+include
source/feat_geom_pkg.sv
source/feat_mem_pkg.sv
source/feat_rd_if.sv
source/feature_sram_rd_addr_encode.sv
source/feat_bank_reader.sv
source/feat_beat_assembler.sv
source/feat_fetch_top.sv
verification/feat_fetch_tb.sv

// ==== source/feat_bank_reader.sv ====
// Single bank storage and burst reader
`include "feat_cfg.svh"

module feat_bank_reader #(
  parameter int unsigned BANK_ID = 0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wr_en,
  input  feat_geom_pkg::word_addr_t wr_addr,
  input  feat_mem_pkg::mem_word_t  wr_data,
  feat_bank_if.mem                 bank
);
  import feat_geom_pkg::*;
  import feat_mem_pkg::*;

  // --------------------
  // storage and write port
  // --------------------
  mem_word_t mem [`FEAT_BANK_DEPTH];

  logic wr_hit;

  // only the writes interleaved onto this bank
  assign wr_hit = wr_en && (wr_addr[0] == bank_sel_t'(BANK_ID));

  always_ff @(posedge clk) begin
    if (wr_hit) begin
      mem[bank_addr_t'(wr_addr >> 1)] <= wr_data;
    end
  end

  // --------------------
  // share of the burst
  // --------------------
  logic       odd_share;
  bank_addr_t first_addr;
  beat_cnt_t  first_cnt;

  // beat parity held here is (bank - start bank) mod 2
  assign odd_share = bank_sel_t'(BANK_ID) ^ bank.start_bank;

  // bank 0 lags by one word when the burst opens in bank 1
  assign first_addr = bank.base_addr
                    + bank_addr_t'(bank_sel_t'(BANK_ID) < bank.start_bank);

  // even beats round up, odd beats round down
  assign first_cnt = odd_share ? (bank.beats >> 1) : ((bank.beats + 4'd1) >> 1);

  // --------------------
  // read sequencer
  // --------------------
  rdr_state_t state;
  beat_cnt_t  remain;
  bank_addr_t rd_addr;
  logic       rd_hit;
  mem_word_t  rd_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= RDR_IDLE;
      remain <= '0;
      rd_hit <= 1'b0;
    end else begin
      // one cycle of read latency
      rd_hit <= (state == RDR_BURST);
      case (state)
        RDR_IDLE: begin
          if (bank.start && (first_cnt != '0)) begin
            state  <= RDR_BURST;
            remain <= first_cnt;
          end
        end
        RDR_BURST: begin
          remain <= remain - 1'b1;
          if (remain == beat_cnt_t'(1)) begin
            state <= RDR_IDLE;
          end
        end
        default: state <= RDR_IDLE;
      endcase
    end
  end

  // address walk and registered read data
  always_ff @(posedge clk) begin
    if (state == RDR_IDLE && bank.start) begin
      rd_addr <= first_addr;
    end else if (state == RDR_BURST) begin
      rd_addr <= rd_addr + 1'b1;
    end
    if (state == RDR_BURST) begin
      rd_data <= mem[rd_addr];
    end
  end

  assign bank.beat_valid = rd_hit;
  assign bank.beat_data  = rd_data;

endmodule

// ==== source/feat_beat_assembler.sv ====
// Burst fan-out and feature assembly
`include "feat_cfg.svh"

module feat_beat_assembler (
  input  logic                     clk,
  input  logic                     rst,
  feat_cmd_if.dst                  cmd,
  feat_bank_if.ctl                 bank0,
  feat_bank_if.ctl                 bank1,
  output logic                     out_valid,
  output feat_geom_pkg::feat_vec_t out_feat,
  output feat_geom_pkg::feat_tag_t out_tag
);
  import feat_geom_pkg::*;
  import feat_mem_pkg::*;

  asm_state_t state;
  logic       take;
  logic       start_q;
  bank_addr_t base_addr;
  bank_sel_t  start_bank;
  beat_cnt_t  beats;
  feat_tag_t  tag;
  feat_vec_t  feat;
  beat_cnt_t  cnt0;
  beat_cnt_t  cnt1;
  beat_cnt_t  got;
  beat_cnt_t  got_next;
  beat_cnt_t  idx0;
  beat_cnt_t  idx1;

  // --------------------
  // command side
  // --------------------
  assign cmd.ready = (state == ASM_IDLE);
  assign take      = cmd.valid && cmd.ready;

  // same burst description to both banks
  assign bank0.start      = start_q;
  assign bank0.base_addr  = base_addr;
  assign bank0.start_bank = start_bank;
  assign bank0.beats      = beats;
  assign bank1.start      = start_q;
  assign bank1.base_addr  = base_addr;
  assign bank1.start_bank = start_bank;
  assign bank1.beats      = beats;

  // --------------------
  // beat placement
  // --------------------
  // bank 0 parity offset is s, bank 1 is the inverse
  assign idx0     = beat_cnt_t'({cnt0, 1'b0}) + beat_cnt_t'(start_bank);
  assign idx1     = beat_cnt_t'({cnt1, 1'b0}) + beat_cnt_t'(!start_bank);
  assign got_next = got + beat_cnt_t'(bank0.beat_valid) + beat_cnt_t'(bank1.beat_valid);

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ASM_IDLE;
      start_q <= 1'b0;
      cnt0    <= '0;
      cnt1    <= '0;
      got     <= '0;
    end else begin
      // start strobe one cycle after the handshake
      start_q <= take;
      case (state)
        ASM_IDLE: begin
          if (take) begin
            state <= ASM_COLLECT;
            cnt0  <= '0;
            cnt1  <= '0;
            got   <= '0;
          end
        end
        ASM_COLLECT: begin
          if (bank0.beat_valid) cnt0 <= cnt0 + 1'b1;
          if (bank1.beat_valid) cnt1 <= cnt1 + 1'b1;
          got <= got_next;
          if (got_next == beats) begin
            state <= ASM_EMIT;
          end
        end
        ASM_EMIT: state <= ASM_IDLE;
        default:  state <= ASM_IDLE;
      endcase
    end
  end

  // latched command fields and feature payload
  always_ff @(posedge clk) begin
    if (take) begin
      base_addr  <= cmd.bank_addr;
      start_bank <= cmd.start_bank;
      beats      <= cmd.beats;
      tag        <= cmd.tag;
    end
    // both banks may land a word in the same cycle
    if (state == ASM_COLLECT && bank0.beat_valid) begin
      feat[idx0*`FEAT_MEM_W +: `FEAT_MEM_W] <= bank0.beat_data;
    end
    if (state == ASM_COLLECT && bank1.beat_valid) begin
      feat[idx1*`FEAT_MEM_W +: `FEAT_MEM_W] <= bank1.beat_data;
    end
  end

  // --------------------
  // result
  // --------------------
  assign out_valid = (state == ASM_EMIT);
  assign out_feat  = feat;
  assign out_tag   = tag;

endmodule

// ==== source/feat_fetch_top.sv ====
// Tiled feature fetch top level

module feat_fetch_top (
  input  logic                      clk,
  input  logic                      rst,
  // bank preload
  input  logic                      wr_en,
  input  feat_geom_pkg::word_addr_t wr_addr,
  input  feat_mem_pkg::mem_word_t   wr_data,
  // tile request from the scheduler
  input  logic                      rd_valid,
  output logic                      rd_ready,
  input  feat_geom_pkg::tile_row_t  rd_row,
  input  feat_geom_pkg::tile_col_t  rd_col,
  input  feat_geom_pkg::feat_tag_t  rd_tag,
  // assembled feature
  output logic                      out_valid,
  output feat_geom_pkg::feat_vec_t  out_feat,
  output feat_geom_pkg::feat_tag_t  out_tag
);

  // --------------------
  // internal links
  // --------------------
  feat_cmd_if  cmd_if ();
  feat_bank_if bank0_if ();
  feat_bank_if bank1_if ();

  // request buffer and address split
  feature_sram_rd_addr_encode i_encode (
    .clk      (clk),
    .rst      (rst),
    .rd_valid (rd_valid),
    .rd_ready (rd_ready),
    .rd_row   (rd_row),
    .rd_col   (rd_col),
    .rd_tag   (rd_tag),
    .cmd      (cmd_if.src)
  );

  // --------------------
  // banks, even and odd words
  // --------------------
  feat_bank_reader #(.BANK_ID(0)) i_rdr0 (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .bank    (bank0_if.mem)
  );

  feat_bank_reader #(.BANK_ID(1)) i_rdr1 (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .bank    (bank1_if.mem)
  );

  // fan-out and packing
  feat_beat_assembler i_asm (
    .clk       (clk),
    .rst       (rst),
    .cmd       (cmd_if.dst),
    .bank0     (bank0_if.ctl),
    .bank1     (bank1_if.ctl),
    .out_valid (out_valid),
    .out_feat  (out_feat),
    .out_tag   (out_tag)
  );

endmodule

// ==== source/feat_geom_pkg.sv ====
// Request-side feature types
`include "feat_cfg.svh"

package feat_geom_pkg;

  // --------------------
  // tile request fields
  // --------------------
  // row and column sized from the tile grid
  typedef logic [$clog2(`FEAT_TILES_Y)-1:0] tile_row_t;
  typedef logic [$clog2(`FEAT_TILES_X)-1:0] tile_col_t;

  // scheduler tag, carried through untouched
  typedef logic [`FEAT_TAG_W-1:0] feat_tag_t;

  // --------------------
  // addressing and payload
  // --------------------
  // global word address before the bank split
  typedef logic [15:0] word_addr_t;

  // burst length in words
  typedef logic [3:0] beat_cnt_t;

  // assembled feature, beat 0 in the low bits
  typedef logic [`FEAT_W-1:0] feat_vec_t;

endpackage

// ==== source/feat_mem_pkg.sv ====
// Bank-side feature store types
`include "feat_cfg.svh"

package feat_mem_pkg;

  // --------------------
  // bank storage
  // --------------------
  // one word as held in a bank
  typedef logic [`FEAT_MEM_W-1:0] mem_word_t;

  // word index inside one bank
  typedef logic [$clog2(`FEAT_BANK_DEPTH)-1:0] bank_addr_t;

  // two banks, interleaved on the low address bit
  typedef logic bank_sel_t;

  // --------------------
  // state machines
  // --------------------
  // bank reader waits or steps through its share
  typedef enum logic {
    RDR_IDLE,
    RDR_BURST
  } rdr_state_t;

  // assembler takes a command, gathers beats and presents the result
  typedef enum logic [1:0] {
    ASM_IDLE,
    ASM_COLLECT,
    ASM_EMIT
  } asm_state_t;

endpackage

// ==== source/feat_rd_if.sv ====
// Feature read path interfaces

// encoder to assembler command with ready/valid
interface feat_cmd_if;
  import feat_geom_pkg::*;
  import feat_mem_pkg::*;

  logic       valid;
  logic       ready;
  bank_addr_t bank_addr;
  bank_sel_t  start_bank;
  beat_cnt_t  beats;
  feat_tag_t  tag;

  // fields held steady while valid and not ready
  modport src (output valid, bank_addr, start_bank, beats, tag, input ready);
  modport dst (input valid, bank_addr, start_bank, beats, tag, output ready);
endinterface

// assembler to one bank reader and back with no back-pressure
interface feat_bank_if;
  import feat_geom_pkg::*;
  import feat_mem_pkg::*;

  logic       start;
  bank_addr_t base_addr;
  bank_sel_t  start_bank;
  beat_cnt_t  beats;
  logic       beat_valid;
  mem_word_t  beat_data;

  modport ctl (output start, base_addr, start_bank, beats, input beat_valid, beat_data);
  modport mem (input start, base_addr, start_bank, beats, output beat_valid, beat_data);
endinterface

// ==== source/feature_sram_rd_addr_encode.sv ====
// Tile request to bank address encoder
`include "feat_cfg.svh"

module feature_sram_rd_addr_encode (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    rd_valid,
  output logic                    rd_ready,
  input  feat_geom_pkg::tile_row_t rd_row,
  input  feat_geom_pkg::tile_col_t rd_col,
  input  feat_geom_pkg::feat_tag_t rd_tag,
  feat_cmd_if.src                 cmd
);
  import feat_geom_pkg::*;

  // --------------------
  // one-deep request buffer
  // --------------------
  logic      buf_full;
  tile_row_t buf_row;
  tile_col_t buf_col;
  feat_tag_t buf_tag;

  logic push;
  logic pop;

  // buffer drains when the assembler accepts the command
  assign pop = buf_full && cmd.ready;

  // free slot, or the current entry leaves this cycle
  assign rd_ready = !buf_full || pop;
  assign push     = rd_valid && rd_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      buf_full <= 1'b0;
    end else begin
      if (push) begin
        buf_full <= 1'b1;
      end else if (pop) begin
        buf_full <= 1'b0;
      end
    end
  end

  // payload captured on push
  always_ff @(posedge clk) begin
    if (push) begin
      buf_row <= rd_row;
      buf_col <= rd_col;
      buf_tag <= rd_tag;
    end
  end

  // --------------------
  // address mapping
  // --------------------
  word_addr_t tile_idx;
  word_addr_t base_word;

  // row-major tile index
  assign tile_idx = word_addr_t'(buf_row) * word_addr_t'(`FEAT_TILES_X)
                  + word_addr_t'(buf_col);

  // each tile owns FEAT_BEATS consecutive words
  assign base_word = word_addr_t'(`FEAT_BASE_WORD)
                   + tile_idx * word_addr_t'(`FEAT_BEATS);

  // --------------------
  // command out
  // --------------------
  assign cmd.valid = buf_full;

  // low bit picks the bank, the rest addresses inside it
  assign cmd.start_bank = base_word[0];
  assign cmd.bank_addr  = base_word[$bits(cmd.bank_addr):1];

  // burst length fixed by the feature width
  assign cmd.beats = beat_cnt_t'(`FEAT_BEATS);
  assign cmd.tag   = buf_tag;

endmodule

// ==== verification/feat_fetch_tb.sv ====
// Feature fetch testbench
`include "feat_cfg.svh"

module feat_fetch_tb;
  import feat_geom_pkg::*;
  import feat_mem_pkg::*;

  // --------------------
  // run sizes
  // --------------------
  localparam int N_TILES = `FEAT_TILES_X * `FEAT_TILES_Y;
  localparam int N_WORDS = `FEAT_BASE_WORD + N_TILES * `FEAT_BEATS;
  localparam int N_RAND  = 32;
  // writes, 8 cycles per request, margin
  localparam int CYCLE_LIMIT = N_WORDS + 8 * (N_TILES + N_RAND) + 100;
  // idle request to out_valid, in clock cycles
  localparam int IDLE_LATENCY = 6;

  logic       clk;
  logic       rst;
  logic       wr_en;
  word_addr_t wr_addr;
  mem_word_t  wr_data;
  logic       rd_valid;
  logic       rd_ready;
  tile_row_t  rd_row;
  tile_col_t  rd_col;
  feat_tag_t  rd_tag;
  logic       out_valid;
  feat_vec_t  out_feat;
  feat_tag_t  out_tag;

  // model state
  mem_word_t model_mem [N_WORDS];
  feat_vec_t exp_feat_q [$];
  feat_tag_t exp_tag_q [$];
  int        exp_due_q [$];
  int        cycle;
  int        hs_count;
  int        out_count;
  int        stall_cycles;
  int        idle_checks;

  feat_fetch_top i_dut (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_valid  (rd_valid),
    .rd_ready  (rd_ready),
    .rd_row    (rd_row),
    .rd_col    (rd_col),
    .rd_tag    (rd_tag),
    .out_valid (out_valid),
    .out_feat  (out_feat),
    .out_tag   (out_tag)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------
  // failure and compare
  // --------------------
  task automatic end_in_failure();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_feat(feat_vec_t exp, feat_vec_t act);
    if (act !== exp) begin
      $display("FAIL t=%0t out_feat expected %h got %h", $time, exp, act);
      end_in_failure();
    end
  endtask

  task automatic check_tag(feat_tag_t exp, feat_tag_t act);
    if (act !== exp) begin
      $display("FAIL t=%0t out_tag expected %h got %h", $time, exp, act);
      end_in_failure();
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (act != exp) begin
      $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, act);
      end_in_failure();
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
      end_in_failure();
    end
  endtask

  // tile words are consecutive from the tile base, beat 0 lowest
  function automatic feat_vec_t expected_feat(tile_row_t row, tile_col_t col);
    feat_vec_t v;
    int        base;
    base = `FEAT_BASE_WORD + (int'(row) * `FEAT_TILES_X + int'(col)) * `FEAT_BEATS;
    v = '0;
    for (int k = 0; k < `FEAT_BEATS; k++) begin
      v[k*`FEAT_MEM_W +: `FEAT_MEM_W] = model_mem[base + k];
    end
    return v;
  endfunction

  // --------------------
  // monitor
  // --------------------
  // sampled mid-cycle, where inputs and outputs are settled
  always @(negedge clk) begin
    cycle = cycle + 1;
    if (cycle > CYCLE_LIMIT) begin
      $display("outputs stalled: cycle limit %0d reached, %0d of %0d outputs seen",
               CYCLE_LIMIT, out_count, hs_count);
      end_in_failure();
    end
    if (!rst) begin
      // quiet output and open request port until the first request
      if (hs_count == 0) begin
        check_flag("out_valid", 1'b0, out_valid);
        check_flag("rd_ready", 1'b1, rd_ready);
      end
      if (out_valid) begin
        // one output per accepted request, never more
        if (exp_feat_q.size() == 0) begin
          check_count("out_valid pulses", hs_count, out_count + 1);
        end
        check_feat(exp_feat_q.pop_front(), out_feat);
        check_tag(exp_tag_q.pop_front(), out_tag);
        if (exp_due_q[0] >= 0) begin
          check_count("out_valid latency cycle", exp_due_q[0], cycle);
          idle_checks = idle_checks + 1;
        end
        void'(exp_due_q.pop_front());
        out_count = out_count + 1;
      end
      if (rd_valid && !rd_ready) begin
        stall_cycles = stall_cycles + 1;
      end
      if (rd_valid && rd_ready) begin
        // nothing outstanding means the pipeline is idle
        exp_due_q.push_back(exp_feat_q.size() == 0 ? cycle + IDLE_LATENCY : -1);
        exp_feat_q.push_back(expected_feat(rd_row, rd_col));
        exp_tag_q.push_back(rd_tag);
        hs_count = hs_count + 1;
      end
    end
  end

  // --------------------
  // stimulus
  // --------------------
  task automatic write_word(word_addr_t addr, mem_word_t data);
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = data;
    model_mem[int'(addr)] = data;
    @(posedge clk);
    #2;
    wr_en = 1'b0;
  endtask

  // hold the request until a cycle with rd_ready high
  task automatic send_req(tile_row_t row, tile_col_t col, feat_tag_t tag);
    logic taken;
    rd_valid = 1'b1;
    rd_row   = row;
    rd_col   = col;
    rd_tag   = tag;
    taken    = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = rd_ready;
      @(posedge clk);
      #2;
    end
    rd_valid = 1'b0;
  endtask

  initial begin
    int gap;
    void'($urandom(96));
    cycle        = 0;
    hs_count     = 0;
    out_count    = 0;
    stall_cycles = 0;
    idle_checks  = 0;
    rst      = 1'b1;
    wr_en    = 1'b0;
    wr_addr  = '0;
    wr_data  = '0;
    rd_valid = 1'b0;
    rd_row   = '0;
    rd_col   = '0;
    rd_tag   = '0;
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;

    // preload every word, banks split on the low address bit
    for (int a = 0; a < N_WORDS; a++) begin
      write_word(word_addr_t'(a), mem_word_t'({$urandom, $urandom}));
    end

    // every tile in order, start banks alternate tile by tile
    for (int r = 0; r < `FEAT_TILES_Y; r++) begin
      for (int c = 0; c < `FEAT_TILES_X; c++) begin
        send_req(tile_row_t'(r), tile_col_t'(c), feat_tag_t'(r * `FEAT_TILES_X + c));
      end
    end

    // random tiles, half back to back, half after a gap
    for (int i = 0; i < N_RAND; i++) begin
      send_req(tile_row_t'($urandom_range(`FEAT_TILES_Y - 1, 0)),
               tile_col_t'($urandom_range(`FEAT_TILES_X - 1, 0)),
               feat_tag_t'($urandom));
      gap = ($urandom_range(1, 0) == 0) ? 0 : int'($urandom_range(9, 1));
      repeat (gap) begin
        @(posedge clk);
        #2;
      end
    end

    // drain, then make sure nothing extra comes out
    while (out_count != hs_count) begin
      @(posedge clk);
    end
    repeat (10) @(posedge clk);
    if (stall_cycles == 0 || idle_checks == 0) begin
      $display("run never hit back-pressure or never checked an idle latency");
      end_in_failure();
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule
